// ==== design/cache.sv ====
`timescale 1ns/1ps

module cache (
    input  logic                              clk,
    input  logic                              rst,

    input  cache_pkg::cache_addr_t            cpu_addr,
    input  logic                              cpu_read,
    input  logic                              cpu_write,
    input  logic [cache_pkg::word_bytes-1:0]  cpu_wmask,
    input  logic [cache_pkg::word_width-1:0]  cpu_wdata,
    output logic [cache_pkg::word_width-1:0]  cpu_rdata,
    output logic                              cache_resp,
    input  logic                              mem_cancel,

    output logic [cache_pkg::addr_width-1:0]  mem_addr,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic [cache_pkg::line_width-1:0]  mem_wdata,
    input  logic [cache_pkg::line_width-1:0]  mem_rdata,
    input  logic                              pmem_resp
);
    import cache_pkg::*;

    dp_ctrl_t dp_ctrl;
    logic     cache_hit;
    logic     cache_dirty; // lru victim valid and dirty

    cache_control control (
        .clk         (clk),
        .rst         (rst),
        .cpu_read    (cpu_read),
        .cpu_write   (cpu_write),
        .mem_cancel  (mem_cancel),
        .cache_resp  (cache_resp),
        .pmem_resp   (pmem_resp),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .dp_ctrl     (dp_ctrl),
        .cache_hit   (cache_hit),
        .cache_dirty (cache_dirty)
    );

    cache_datapath datapath (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_wmask   (cpu_wmask),
        .cpu_rdata   (cpu_rdata),
        .dp_ctrl     (dp_ctrl),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .cache_hit   (cache_hit),
        .cache_dirty (cache_dirty)
    );

endmodule

// ==== design/cache_control.sv ====
`timescale 1ns/1ps

module cache_control (
    input  logic                clk,
    input  logic                rst,

    input  logic                cpu_read,
    input  logic                cpu_write,
    input  logic                mem_cancel,
    output logic                cache_resp,

    input  logic                pmem_resp,
    output logic                mem_read,
    output logic                mem_write,

    output cache_pkg::dp_ctrl_t dp_ctrl,
    input  logic                cache_hit,
    input  logic                cache_dirty
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        hit_look   = 2'd1,
        write_back = 2'd2,
        allocate   = 2'd3
    } state_t;

    state_t state;
    state_t next_state;
    logic   ex_read;
    logic   ex_write;

    // read and write together counts as no request
    assign ex_read  = cpu_read && !cpu_write;
    assign ex_write = cpu_write && !cpu_read;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (mem_cancel && state != idle) begin
            next_state = idle; // drop whatever is in flight
        end else begin
            case (state)
                idle: begin
                    if (ex_read || ex_write) next_state = hit_look;
                end
                hit_look: begin
                    if (cache_hit) begin
                        next_state = idle;
                    end else if (cache_dirty) begin
                        next_state = write_back;
                    end else begin
                        next_state = allocate;
                    end
                end
                write_back: begin
                    if (pmem_resp) next_state = allocate;
                end
                allocate: begin
                    if (pmem_resp) next_state = hit_look; // replay lookup on the new line
                end
                default: next_state = idle;
            endcase
        end
    end

    always_comb begin
        cache_resp            = 1'b0;
        mem_read              = 1'b0;
        mem_write             = 1'b0;
        dp_ctrl.dirty_op      = dirty_none;
        dp_ctrl.valid_op      = valid_none;
        dp_ctrl.plru_update   = 1'b0;
        dp_ctrl.dataweb_sel   = web_none;
        dp_ctrl.tag_we        = 1'b0;
        dp_ctrl.datain_sel    = sel_cpu;
        dp_ctrl.dataout_sel   = sel_hit;
        dp_ctrl.dirty_way_sel = sel_hit;
        dp_ctrl.pmem_addr_sel = sel_cpu;
        dp_ctrl.wmask_sel     = sel_mask;

        case (state)
            hit_look: begin
                if (cache_hit && !mem_cancel) begin
                    cache_resp          = 1'b1;
                    dp_ctrl.plru_update = 1'b1;
                    if (ex_write) begin
                        // merge cpu word into the hit line, mark it dirty
                        dp_ctrl.dataweb_sel   = web_cpu;
                        dp_ctrl.datain_sel    = sel_cpu;
                        dp_ctrl.wmask_sel     = sel_mask;
                        dp_ctrl.dirty_op      = dirty_set;
                        dp_ctrl.dirty_way_sel = sel_hit;
                    end
                end
            end
            write_back: begin
                mem_write             = 1'b1;
                dp_ctrl.pmem_addr_sel = sel_victim;
                dp_ctrl.dataout_sel   = sel_victim; // victim line onto mem_wdata
                if (pmem_resp) begin
                    dp_ctrl.dirty_op      = dirty_clear;
                    dp_ctrl.dirty_way_sel = sel_victim;
                end
            end
            allocate: begin
                mem_read              = 1'b1;
                dp_ctrl.pmem_addr_sel = sel_cpu;
                if (pmem_resp) begin
                    dp_ctrl.dataweb_sel = web_fill;
                    dp_ctrl.datain_sel  = sel_mem;
                    dp_ctrl.wmask_sel   = sel_full;
                    dp_ctrl.tag_we      = 1'b1;
                    dp_ctrl.valid_op    = valid_set;
                end
            end
            default: ;
        endcase
    end

    // one memory strobe at a time
    assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    assert property (@(posedge clk) disable iff (rst) (state == idle) |-> !cache_resp)
        else $error("cache_resp raised in idle");

endmodule

// ==== design/cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath (
    input  logic                               clk,
    input  logic                               rst,
    input  cache_pkg::cache_addr_t             cpu_addr,
    input  logic [cache_pkg::word_width-1:0]   cpu_wdata,
    input  logic [cache_pkg::word_bytes-1:0]   cpu_wmask,
    output logic [cache_pkg::word_width-1:0]   cpu_rdata,
    input  cache_pkg::dp_ctrl_t                dp_ctrl,
    input  logic [cache_pkg::line_width-1:0]   mem_rdata,
    output logic [cache_pkg::addr_width-1:0]   mem_addr,
    output logic [cache_pkg::line_width-1:0]   mem_wdata,
    output logic                               cache_hit,
    output logic                               cache_dirty
);
    import cache_pkg::*;

    logic [tag_width-1:0]   tag_arr   [num_ways][num_sets];
    logic [line_width-1:0]  data_arr  [num_ways][num_sets];
    logic [num_sets-1:0]    valid_arr [num_ways];
    logic [num_sets-1:0]    dirty_arr [num_ways];
    logic [num_sets-1:0]    plru;       // bit per set names the lru way

    logic [index_width-1:0] idx;
    logic [num_ways-1:0]    way_hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   dirty_way;
    logic                   web_way;
    logic [line_width-1:0]  out_line;
    logic [line_width-1:0]  in_line;
    logic [line_bytes-1:0]  line_wmask;

    assign idx = cpu_addr.f.index;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = valid_arr[w][idx] && (tag_arr[w][idx] == cpu_addr.f.tag);
        end
    end

    assign cache_hit   = |way_hit;
    assign hit_way     = way_hit[1];
    assign victim_way  = plru[idx];
    assign cache_dirty = valid_arr[victim_way][idx] && dirty_arr[victim_way][idx];

    // way selects for the write ports
    assign dirty_way = (dp_ctrl.dirty_way_sel == sel_victim) ? victim_way : hit_way;
    assign web_way   = (dp_ctrl.dataweb_sel == web_cpu) ? hit_way : victim_way;

    // read side
    assign out_line  = (dp_ctrl.dataout_sel == sel_victim) ? data_arr[victim_way][idx]
                                                           : data_arr[hit_way][idx];
    assign cpu_rdata = out_line[cpu_addr.f.word_sel*word_width +: word_width];
    assign mem_wdata = out_line;

    always_comb begin
        if (dp_ctrl.pmem_addr_sel == sel_victim) begin
            mem_addr = {tag_arr[victim_way][idx], idx, {offset_width{1'b0}}};
        end else begin
            mem_addr = {cpu_addr.raw[addr_width-1:offset_width], {offset_width{1'b0}}};
        end
    end

    // write side, cpu word replicated across the line and masked into place
    assign in_line = (dp_ctrl.datain_sel == sel_mem) ? mem_rdata : {words_per_line{cpu_wdata}};

    always_comb begin
        if (dp_ctrl.wmask_sel == sel_full) begin
            line_wmask = '1;
        end else begin
            line_wmask = line_bytes'(cpu_wmask) << (cpu_addr.f.word_sel * word_bytes);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_arr[w] <= '0;
                dirty_arr[w] <= '0;
            end
            plru <= '0;
        end else begin
            if (dp_ctrl.valid_op == valid_set) valid_arr[victim_way][idx] <= 1'b1;
            case (dp_ctrl.dirty_op)
                dirty_set:   dirty_arr[dirty_way][idx] <= 1'b1;
                dirty_clear: dirty_arr[dirty_way][idx] <= 1'b0;
                default: ;
            endcase
            if (dp_ctrl.plru_update) plru[idx] <= ~hit_way; // other way becomes lru
        end
    end

    always_ff @(posedge clk) begin
        if (dp_ctrl.tag_we) tag_arr[victim_way][idx] <= cpu_addr.f.tag;
        if (dp_ctrl.dataweb_sel != web_none) begin
            for (int b = 0; b < line_bytes; b++) begin
                if (line_wmask[b]) begin
                    data_arr[web_way][idx][8*b +: 8] <= in_line[8*b +: 8];
                end
            end
        end
    end

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (rst) !(&way_hit))
        else $error("both ways hit in set %0d", idx);

endmodule

// ==== design/cache_pkg.sv ====
package cache_pkg;

    // geometry
    localparam int addr_width     = 32;
    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int line_width     = word_width * words_per_line;
    localparam int word_bytes     = word_width / 8;
    localparam int line_bytes     = line_width / 8;
    localparam int num_sets       = 8;
    localparam int num_ways       = 2;
    localparam int index_width    = $clog2(num_sets);
    localparam int offset_width   = 4;
    localparam int word_sel_width = $clog2(words_per_line);
    localparam int byte_sel_width = offset_width - word_sel_width;
    localparam int tag_width      = addr_width - index_width - offset_width;

    // dirty_op / valid_op / dataweb_sel encodings
    localparam logic [1:0] dirty_none  = 2'b00;
    localparam logic [1:0] dirty_set   = 2'b01;
    localparam logic [1:0] dirty_clear = 2'b10;
    localparam logic [1:0] valid_none  = 2'b00;
    localparam logic [1:0] valid_set   = 2'b01;
    localparam logic [1:0] web_none    = 2'b00;
    localparam logic [1:0] web_cpu     = 2'b01;
    localparam logic [1:0] web_fill    = 2'b10;

    // one-bit select values
    localparam logic sel_hit    = 1'b0;
    localparam logic sel_victim = 1'b1;
    localparam logic sel_cpu    = 1'b0;
    localparam logic sel_mem    = 1'b1;
    localparam logic sel_mask   = 1'b0;
    localparam logic sel_full   = 1'b1;

    typedef struct packed {
        logic [tag_width-1:0]      tag;
        logic [index_width-1:0]    index;
        logic [word_sel_width-1:0] word_sel;
        logic [byte_sel_width-1:0] byte_sel;
    } addr_fields_t;

    // same 32 bits, seen as a raw address or as cache fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        addr_fields_t          f;
    } cache_addr_t;

    typedef struct packed {
        logic [1:0] dirty_op;
        logic [1:0] valid_op;
        logic       plru_update;
        logic [1:0] dataweb_sel;
        logic       tag_we;
        logic       datain_sel;
        logic       dataout_sel;
        logic       dirty_way_sel;
        logic       pmem_addr_sel;
        logic       wmask_sel;
    } dp_ctrl_t;

endpackage

// ==== files.f ====
design/cache_pkg.sv
design/cache_control.sv
design/cache_datapath.sv
design/cache.sv
sim/pmem_model.sv
sim/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f files.f --top-module cache_tb -o cache_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cache_tb_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Regression failed" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int timeout_cycles = 4000; // roughly four times the full sequence

    logic                  clk;
    logic                  rst;
    cache_addr_t           cpu_addr;
    logic                  cpu_read;
    logic                  cpu_write;
    logic [word_bytes-1:0] cpu_wmask;
    logic [word_width-1:0] cpu_wdata;
    logic [word_width-1:0] cpu_rdata;
    logic                  cache_resp;
    logic                  mem_cancel;
    logic [addr_width-1:0] mem_addr;
    logic                  mem_read;
    logic                  mem_write;
    logic [line_width-1:0] mem_wdata;
    logic [line_width-1:0] mem_rdata;
    logic                  pmem_resp;

    logic [word_width-1:0] shadow [logic [29:0]]; // keyed by word address
    logic [word_width-1:0] exp_rdata;
    logic                  hit_expected;
    logic                  cancelled;
    logic [addr_width-1:0] last_wb_addr;
    int                    req_age;
    int                    mem_reads;
    int                    wb_count;
    int                    cycle_count;
    integer                seed = 32'h45e7;

    cache UUT (.*);
    pmem_model memory (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] word;
        word = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
        return {2'b00, addr[31:2]} ^ 32'ha5a5_0000; // untouched memory pattern
    endfunction

    function automatic logic [31:0] addr_of(input int tag, input int set, input int word);
        cache_addr_t a;
        a.raw        = '0;
        a.f.tag      = tag_width'(tag);
        a.f.index    = index_width'(set);
        a.f.word_sel = word_sel_width'(word);
        return a.raw;
    endfunction

    // one cpu request, held until cache_resp
    task automatic cpu_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] mask,
                              input logic want_hit);
        @(posedge clk);
        cpu_addr.raw <= addr;
        cpu_read     <= !is_write;
        cpu_write    <= is_write;
        cpu_wdata    <= data;
        cpu_wmask    <= mask;
        exp_rdata    <= shadow_word(addr);
        hit_expected <= want_hit;
        cancelled    <= 1'b0;
        @(negedge clk);
        while (!cache_resp) @(negedge clk);
        if (is_write) shadow[addr[31:2]] = merge_word(shadow_word(addr), data, mask);
        @(posedge clk);
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;
    endtask

    task automatic cancel_in_allocate(input logic [31:0] addr);
        @(posedge clk);
        cpu_addr.raw <= addr;
        cpu_read     <= 1'b1;
        cpu_write    <= 1'b0;
        exp_rdata    <= shadow_word(addr);
        hit_expected <= 1'b0;
        cancelled    <= 1'b1;
        @(negedge clk);
        while (!mem_read) @(negedge clk); // allocate has started
        @(posedge clk);
        mem_cancel <= 1'b1;
        @(posedge clk);
        mem_cancel <= 1'b0;
        cpu_read   <= 1'b0;
        repeat (6) @(posedge clk); // quiet window for the no-response check
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        req_age     <= (cpu_read || cpu_write) ? req_age + 1 : 0;
    end

    always @(negedge clk) begin
        if (!rst && pmem_resp && mem_read) mem_reads <= mem_reads + 1;
        if (!rst && pmem_resp && mem_write) begin
            wb_count     <= wb_count + 1;
            last_wb_addr <= mem_addr;
        end
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        abort_run($sformatf("timeout after %0d cycles with no end of test", cycle_count));
    end

    read_data_check: assert property (@(posedge clk) disable iff (rst)
        (cache_resp && cpu_read && !cpu_write) |-> (cpu_rdata == exp_rdata))
        else report_mismatch($sformatf("read data %h, expected %h",
                                       $sampled(cpu_rdata), $sampled(exp_rdata)));

    line_align_check: assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) |-> (mem_addr[offset_width-1:0] == '0))
        else report_mismatch($sformatf("mem_addr %h not line aligned", $sampled(mem_addr)));

    cancel_check: assert property (@(posedge clk) disable iff (rst) cancelled |-> !cache_resp)
        else report_mismatch("cache_resp given for a cancelled request");

    hit_latency_check: assert property (@(posedge clk) disable iff (rst)
        (hit_expected && (cpu_read || cpu_write)) |-> (cache_resp == (req_age == 1)))
        else report_mismatch($sformatf("hit response at request age %0d", $sampled(req_age)));

    initial begin
        logic [31:0] a, b, c, d, e, f, g, addr, wdata, r;
        int          reads_before;
        int          wb_before;
        int unsigned pick;

        rst          = 1'b1;
        cpu_addr     = '0;
        cpu_read     = 1'b0;
        cpu_write    = 1'b0;
        cpu_wmask    = '0;
        cpu_wdata    = '0;
        mem_cancel   = 1'b0;
        exp_rdata    = '0;
        hit_expected = 1'b0;
        cancelled    = 1'b0;
        last_wb_addr = '0;
        req_age      = 0;
        mem_reads    = 0;
        wb_count     = 0;
        cycle_count  = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // read miss then hit on the same line
        a = addr_of(1, 2, 1);
        reads_before = mem_reads;
        cpu_access(1'b0, a, '0, '0, 1'b0);
        cpu_access(1'b0, a, '0, '0, 1'b1);
        assert (mem_reads == reads_before + 1) else report_mismatch("line not fetched once");

        // partial write hit, then read back the merged word
        cpu_access(1'b1, a, 32'h1234_5678, 4'b0110, 1'b1);
        cpu_access(1'b0, a, '0, '0, 1'b1);

        // two more tags in set 2 push the dirty line out
        b = addr_of(2, 2, 0);
        c = addr_of(3, 2, 3);
        cpu_access(1'b0, b, '0, '0, 1'b0);
        wb_before = wb_count;
        cpu_access(1'b0, c, '0, '0, 1'b0);
        assert (wb_count == wb_before + 1 && last_wb_addr == {a[31:4], 4'h0})
            else report_mismatch("dirty line not written back to its address");
        reads_before = mem_reads;
        cpu_access(1'b0, a, '0, '0, 1'b0);
        assert (mem_reads == reads_before + 1) else report_mismatch("evicted line still cached");

        // lru order in set 5
        d = addr_of(4, 5, 0);
        e = addr_of(5, 5, 1);
        f = addr_of(6, 5, 2);
        cpu_access(1'b0, d, '0, '0, 1'b0);
        cpu_access(1'b0, e, '0, '0, 1'b0);
        cpu_access(1'b0, d, '0, '0, 1'b1);
        cpu_access(1'b0, f, '0, '0, 1'b0); // e is lru here
        cpu_access(1'b0, d, '0, '0, 1'b1);
        reads_before = mem_reads;
        cpu_access(1'b0, e, '0, '0, 1'b0);
        assert (mem_reads == reads_before + 1) else report_mismatch("lru way was not replaced");

        // cancel during allocate, then the same request again
        g = addr_of(7, 6, 2);
        cancel_in_allocate(g);
        cpu_access(1'b0, g, '0, '0, 1'b0);

        // random mix over sets 0 to 3 and six tags
        for (int i = 0; i < 200; i++) begin
            r     = $random(seed);
            wdata = $random(seed);
            pick  = r[31:8] % 6;
            addr  = addr_of(int'(pick) + 8, int'(r[1:0]), int'(r[3:2]));
            cpu_access(r[4], addr, wdata, r[8:5], 1'b0);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== sim/pmem_model.sv ====
`timescale 1ns/1ps

module pmem_model (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cache_pkg::addr_width-1:0] mem_addr,
    input  logic                             mem_read,
    input  logic                             mem_write,
    input  logic [cache_pkg::line_width-1:0] mem_wdata,
    output logic [cache_pkg::line_width-1:0] mem_rdata,
    output logic                             pmem_resp
);
    import cache_pkg::*;

    logic [line_width-1:0] lines [logic [addr_width-1:0]]; // only lines written back
    integer                seed = 32'h45e7;
    int                    wait_left;
    logic                  busy;

    // every word starts as its word address xor a fixed pattern
    function automatic logic [line_width-1:0] read_line(input logic [addr_width-1:0] addr);
        logic [line_width-1:0] line;
        logic [addr_width-1:0] word_addr;
        if (lines.exists(addr)) return lines[addr];
        for (int w = 0; w < words_per_line; w++) begin
            word_addr = {2'b00, addr[addr_width-1:offset_width], 2'(w)};
            line[w*word_width +: word_width] = word_addr ^ 32'ha5a5_0000;
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            wait_left <= 0;
            pmem_resp <= 1'b0;
            mem_rdata <= '0;
        end else begin
            pmem_resp <= 1'b0;
            if ((mem_read || mem_write) && !pmem_resp) begin
                if (!busy) begin
                    busy      <= 1'b1;
                    wait_left <= int'($unsigned($random(seed)) % 32'd4); // 1 to 4 cycles in all
                end else if (wait_left == 0) begin
                    busy      <= 1'b0;
                    pmem_resp <= 1'b1;
                    if (mem_write) begin
                        lines[mem_addr] = mem_wdata;
                    end else begin
                        mem_rdata <= read_line(mem_addr);
                    end
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else begin
                busy <= 1'b0; // strobe dropped or just answered
            end
        end
    end

endmodule
